//--- design/csi2_tx_settings.svh
`ifndef CSI2_TX_SETTINGS_SVH
`define CSI2_TX_SETTINGS_SVH

// Pixel lines per frame, 12 bits at most
`define CSI2_PIXEL_LINES 4

// Bytes per RAW10 line, a multiple of 10 on two lanes
`define CSI2_LINE_BYTES 10

// Bytes per embedded-data line
`define CSI2_EMBEDDED_BYTES 10

// Settle delay after the stream request
`define CSI2_TINIT_WAIT 4

// HS request pulse length
`define CSI2_HS_PULSE 6

// HS ready to sp_en/lp_en
`define CSI2_PKT_EN_DELAY 7

`define CSI2_EXPOSURE 16   // Simulated exposure between frames

// Last frame number before wrapping to 1
`define CSI2_FRAME_WRAP 65534

`endif

//--- design/csi2_proto_pkg.sv
package csi2_proto_pkg;

	typedef logic [7:0] lane_byte_t;    // One byte on one lane
	typedef logic [15:0] word_count_t;  // Header WC field
	typedef logic [5:0] data_type_t;    // Header DT field
	typedef logic [9:0] pixel_t;        // One RAW10 sample

	// Short packet codes
	localparam data_type_t DT_FRAME_START = 6'h00;
	localparam data_type_t DT_FRAME_END   = 6'h01;

	// Long packet codes
	localparam data_type_t DT_EMBEDDED = 6'h12;
	localparam data_type_t DT_RAW10    = 6'h2B;

	// Embedded line bytes
	localparam lane_byte_t EMB_FORMAT = 8'h0A;  // Format code
	localparam lane_byte_t EMB_END    = 8'h07;  // Data end code
	localparam lane_byte_t EMB_DUMMY  = 8'h55;

endpackage

//--- design/tx_ctrl_pkg.sv
package tx_ctrl_pkg;

	// Link bring-up steps
	typedef enum logic [1:0] {
		LINK_WAIT_LOCK,
		LINK_WAIT_TINIT,
		LINK_WAIT_START,
		LINK_SETTLE
	} link_state_t;

	typedef enum logic [3:0] {
		SEQ_IDLE,       // Waiting for link up
		SEQ_HS,         // HS request pulse
		SEQ_HS_RDY,     // Waiting for data lane HS ready
		SEQ_PKT_DLY,    // Delay before sp_en or lp_en
		SEQ_SP_EN,
		SEQ_LP_EN,
		SEQ_WAIT_PYLD,  // Waiting for payload load to drop
		SEQ_PYLD_GAP,
		SEQ_DATA,
		SEQ_DATA_LAST,
		SEQ_WAIT_C2D,   // Between packets of a frame
		SEQ_FRAME_GAP,  // After FE, stream check
		SEQ_EXPOSE,
		SEQ_DROP
	} seq_state_t;

	typedef enum logic {
		LP_EMBEDDED,
		LP_PIXEL
	} lp_kind_t;

	typedef logic [11:0] line_count_t;  // Remaining pixel lines

endpackage

//--- design/delay_timer.sv
`timescale 1ns/100ps

module delay_timer #(
	parameter int DELAY = 4
) (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic start_i,
	output logic done_o
);

	localparam int CW = (DELAY > 1) ? $clog2(DELAY) : 1;

	logic [CW-1:0] count_q;

	// Reloads while idle, counts down while start is held
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q <= CW'(DELAY - 1);
			done_o  <= 1'b0;
		end else begin
			if (!start_i) begin
				count_q <= CW'(DELAY - 1);
			end else if (count_q != '0) begin
				count_q <= count_q - 1'b1;
			end
			done_o <= start_i && (count_q == '0);  // Held until start falls
		end
	end

endmodule

//--- design/link_bringup.sv
`timescale 1ns/100ps
`include "csi2_tx_settings.svh"

module link_bringup (
	input  logic ctrl_tx_byte_clk_i,
	input  logic ctrl_tx_reset_i,
	input  logic pll_lock_i,
	input  logic tinit_done_i,
	input  logic start_stream_i,
	input  logic link_drop_i,
	output logic link_up_o,
	output logic stream_on_o
);

	tx_ctrl_pkg::link_state_t state_q;
	logic settle_done;

	// Settle delay counts from the cycle the request was seen
	delay_timer #(
		.DELAY(`CSI2_TINIT_WAIT + 1)
	) u_settle_timer (
		.clk_i  (ctrl_tx_byte_clk_i),
		.rst_n_i(ctrl_tx_reset_i),
		.start_i(state_q == tx_ctrl_pkg::LINK_SETTLE),
		.done_o (settle_done)
	);

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			state_q <= tx_ctrl_pkg::LINK_WAIT_LOCK;
		end else begin
			case (state_q)
				tx_ctrl_pkg::LINK_WAIT_LOCK: begin
					if (pll_lock_i) begin
						state_q <= tx_ctrl_pkg::LINK_WAIT_TINIT;
					end
				end
				tx_ctrl_pkg::LINK_WAIT_TINIT: begin
					if (tinit_done_i) begin
						state_q <= tx_ctrl_pkg::LINK_WAIT_START;
					end
				end
				tx_ctrl_pkg::LINK_WAIT_START: begin
					if (start_stream_i) begin
						state_q <= tx_ctrl_pkg::LINK_SETTLE;
					end
				end
				tx_ctrl_pkg::LINK_SETTLE: begin
					if (link_drop_i) begin
						state_q <= tx_ctrl_pkg::LINK_WAIT_START;  // Stopped at frame boundary
					end
				end
				default: state_q <= tx_ctrl_pkg::LINK_WAIT_LOCK;
			endcase
		end
	end

	// Timer done lingers one cycle after leaving SETTLE, so qualify it
	assign link_up_o   = settle_done && (state_q == tx_ctrl_pkg::LINK_SETTLE);
	assign stream_on_o = start_stream_i && (state_q == tx_ctrl_pkg::LINK_SETTLE);

endmodule

//--- design/packet_sequencer.sv
`timescale 1ns/100ps
`include "csi2_tx_settings.svh"

module packet_sequencer (
	input  logic                        ctrl_tx_byte_clk_i,
	input  logic                        ctrl_tx_reset_i,
	input  logic                        link_up_i,
	input  logic                        stream_on_i,
	input  logic                        c2d_ready_i,
	input  logic                        d_hs_rdy_i,
	input  logic                        ld_pyld_i,
	input  logic                        payload_last_i,
	output logic                        link_drop_o,
	output logic                        clk_hs_en_o,
	output logic                        d_hs_en_o,
	output logic                        sp_en_o,
	output logic                        lp_en_o,
	output logic                        payload_run_o,
	output tx_ctrl_pkg::lp_kind_t       lp_kind_o,
	output logic                        line_odd_o,
	output csi2_proto_pkg::data_type_t  dt_o,
	output csi2_proto_pkg::word_count_t wc_o,
	output tx_ctrl_pkg::line_count_t    line_num_o
);

	tx_ctrl_pkg::seq_state_t state_q;
	csi2_proto_pkg::word_count_t frame_cnt_q;
	logic short_pkt_q;   // Next packet is FS or FE
	logic frame_end_q;   // Short packet is FE
	logic emb_second_q;  // First embedded line already sent
	logic hs_done;
	logic pkt_done;
	logic exp_done;

	// Pulse ends one cycle after done is seen
	delay_timer #(
		.DELAY(`CSI2_HS_PULSE - 1)
	) u_hs_timer (
		.clk_i  (ctrl_tx_byte_clk_i),
		.rst_n_i(ctrl_tx_reset_i),
		.start_i(state_q == tx_ctrl_pkg::SEQ_HS),
		.done_o (hs_done)
	);

	delay_timer #(
		.DELAY(`CSI2_PKT_EN_DELAY - 1)
	) u_pkt_en_timer (
		.clk_i  (ctrl_tx_byte_clk_i),
		.rst_n_i(ctrl_tx_reset_i),
		.start_i(state_q == tx_ctrl_pkg::SEQ_PKT_DLY),
		.done_o (pkt_done)
	);

	delay_timer #(
		.DELAY(`CSI2_EXPOSURE)
	) u_exposure_timer (
		.clk_i  (ctrl_tx_byte_clk_i),
		.rst_n_i(ctrl_tx_reset_i),
		.start_i(state_q == tx_ctrl_pkg::SEQ_EXPOSE),
		.done_o (exp_done)
	);

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			state_q      <= tx_ctrl_pkg::SEQ_IDLE;
			frame_cnt_q  <= 16'd1;
			short_pkt_q  <= 1'b1;
			frame_end_q  <= 1'b0;
			emb_second_q <= 1'b0;
			lp_kind_o    <= tx_ctrl_pkg::LP_EMBEDDED;
			line_odd_o   <= 1'b0;
			line_num_o   <= tx_ctrl_pkg::line_count_t'(`CSI2_PIXEL_LINES);
			dt_o         <= '0;
			wc_o         <= '0;
		end else begin
			case (state_q)
				tx_ctrl_pkg::SEQ_IDLE: begin
					if (link_up_i) begin
						state_q <= tx_ctrl_pkg::SEQ_HS;  // First FS skips exposure
					end
				end
				tx_ctrl_pkg::SEQ_HS: begin
					if (hs_done) begin
						state_q <= tx_ctrl_pkg::SEQ_HS_RDY;
					end
				end
				tx_ctrl_pkg::SEQ_HS_RDY: begin
					if (d_hs_rdy_i) begin
						if (short_pkt_q) begin
							dt_o <= frame_end_q ? csi2_proto_pkg::DT_FRAME_END :
								csi2_proto_pkg::DT_FRAME_START;
							wc_o <= frame_cnt_q;  // Frame number rides in WC
						end else if (lp_kind_o == tx_ctrl_pkg::LP_EMBEDDED) begin
							dt_o <= csi2_proto_pkg::DT_EMBEDDED;
							wc_o <= csi2_proto_pkg::word_count_t'(`CSI2_EMBEDDED_BYTES);
						end else begin
							dt_o <= csi2_proto_pkg::DT_RAW10;
							wc_o <= csi2_proto_pkg::word_count_t'(`CSI2_LINE_BYTES);
						end
						state_q <= tx_ctrl_pkg::SEQ_PKT_DLY;
					end
				end
				tx_ctrl_pkg::SEQ_PKT_DLY: begin
					if (pkt_done) begin
						state_q <= short_pkt_q ? tx_ctrl_pkg::SEQ_SP_EN : tx_ctrl_pkg::SEQ_LP_EN;
					end
				end
				tx_ctrl_pkg::SEQ_SP_EN: begin
					if (frame_end_q) begin
						frame_end_q <= 1'b0;  // Next short packet is FS again
						state_q     <= tx_ctrl_pkg::SEQ_FRAME_GAP;
					end else begin
						short_pkt_q  <= 1'b0;
						emb_second_q <= 1'b0;
						lp_kind_o    <= tx_ctrl_pkg::LP_EMBEDDED;
						line_odd_o   <= 1'b0;
						line_num_o   <= tx_ctrl_pkg::line_count_t'(`CSI2_PIXEL_LINES);
						state_q      <= tx_ctrl_pkg::SEQ_WAIT_C2D;
					end
				end
				tx_ctrl_pkg::SEQ_LP_EN: state_q <= tx_ctrl_pkg::SEQ_WAIT_PYLD;
				tx_ctrl_pkg::SEQ_WAIT_PYLD: begin
					if (!ld_pyld_i) begin
						state_q <= tx_ctrl_pkg::SEQ_PYLD_GAP;
					end
				end
				tx_ctrl_pkg::SEQ_PYLD_GAP: state_q <= tx_ctrl_pkg::SEQ_DATA;  // IP latch margin
				tx_ctrl_pkg::SEQ_DATA: begin
					if (payload_last_i) begin
						state_q <= tx_ctrl_pkg::SEQ_DATA_LAST;
					end
				end
				tx_ctrl_pkg::SEQ_DATA_LAST: begin
					state_q <= tx_ctrl_pkg::SEQ_WAIT_C2D;
					if (lp_kind_o == tx_ctrl_pkg::LP_EMBEDDED) begin
						if (emb_second_q) begin
							lp_kind_o <= tx_ctrl_pkg::LP_PIXEL;
						end
						emb_second_q <= 1'b1;
					end else if (line_num_o == tx_ctrl_pkg::line_count_t'(1)) begin
						short_pkt_q <= 1'b1;  // Last line done, FE follows
						frame_end_q <= 1'b1;
					end else begin
						line_num_o <= line_num_o - 1'b1;
						line_odd_o <= ~line_odd_o;  // Alternate R/Gr and Gb/B rows
					end
				end
				tx_ctrl_pkg::SEQ_WAIT_C2D: begin
					if (c2d_ready_i) begin
						state_q <= tx_ctrl_pkg::SEQ_HS;
					end
				end
				tx_ctrl_pkg::SEQ_FRAME_GAP: begin
					if (!stream_on_i) begin
						state_q <= tx_ctrl_pkg::SEQ_DROP;
					end else if (c2d_ready_i) begin
						if (frame_cnt_q == csi2_proto_pkg::word_count_t'(`CSI2_FRAME_WRAP)) begin
							frame_cnt_q <= 16'd1;
						end else begin
							frame_cnt_q <= frame_cnt_q + 1'b1;
						end
						state_q <= tx_ctrl_pkg::SEQ_EXPOSE;
					end
				end
				tx_ctrl_pkg::SEQ_EXPOSE: begin
					if (exp_done) begin
						state_q <= tx_ctrl_pkg::SEQ_HS;
					end
				end
				tx_ctrl_pkg::SEQ_DROP: begin
					frame_cnt_q <= 16'd1;  // Restart numbering on the next stream
					state_q     <= tx_ctrl_pkg::SEQ_IDLE;
				end
				default: state_q <= tx_ctrl_pkg::SEQ_IDLE;
			endcase
		end
	end

	assign clk_hs_en_o   = (state_q == tx_ctrl_pkg::SEQ_HS);
	assign d_hs_en_o     = (state_q == tx_ctrl_pkg::SEQ_HS);
	assign sp_en_o       = (state_q == tx_ctrl_pkg::SEQ_SP_EN);
	assign lp_en_o       = (state_q == tx_ctrl_pkg::SEQ_LP_EN);
	assign link_drop_o   = (state_q == tx_ctrl_pkg::SEQ_DROP);
	assign payload_run_o = (state_q == tx_ctrl_pkg::SEQ_DATA) ||
		(state_q == tx_ctrl_pkg::SEQ_DATA_LAST);

endmodule

//--- design/payload_gen.sv
`timescale 1ns/100ps
`include "csi2_tx_settings.svh"

module payload_gen (
	input  logic                       ctrl_tx_byte_clk_i,
	input  logic                       ctrl_tx_reset_i,
	input  logic                       payload_run_i,
	input  tx_ctrl_pkg::lp_kind_t      lp_kind_i,
	input  logic                       line_odd_i,
	input  csi2_proto_pkg::pixel_t     pixel_red_i,
	input  csi2_proto_pkg::pixel_t     pixel_green_red_i,
	input  csi2_proto_pkg::pixel_t     pixel_green_blue_i,
	input  csi2_proto_pkg::pixel_t     pixel_blue_i,
	output csi2_proto_pkg::lane_byte_t lane0_o,
	output csi2_proto_pkg::lane_byte_t lane1_o,
	output logic                       payload_last_o
);

	// Beat index that raises payload_last one beat before the end
	localparam csi2_proto_pkg::word_count_t EMB_LAST =
		csi2_proto_pkg::word_count_t'(`CSI2_EMBEDDED_BYTES / 2 - 2);
	localparam csi2_proto_pkg::word_count_t PIX_LAST =
		csi2_proto_pkg::word_count_t'(`CSI2_LINE_BYTES / 2 - 2);

	logic [2:0] step_q;
	logic [2:0] step_nxt;
	csi2_proto_pkg::word_count_t beat_q;
	csi2_proto_pkg::word_count_t last_beat;
	csi2_proto_pkg::pixel_t pix_a;
	csi2_proto_pkg::pixel_t pix_b;
	csi2_proto_pkg::lane_byte_t pix_l;  // Packed low bits
	csi2_proto_pkg::lane_byte_t lane0_q;
	csi2_proto_pkg::lane_byte_t lane1_q;
	csi2_proto_pkg::lane_byte_t lane0_nxt;
	csi2_proto_pkg::lane_byte_t lane1_nxt;

	// Gear step of the following cycle parks at 0 between lines
	assign step_nxt = !payload_run_i ? 3'd0 :
		(step_q == 3'd4) ? 3'd0 : step_q + 3'd1;

	assign pix_a = line_odd_i ? pixel_green_blue_i : pixel_red_i;
	assign pix_b = line_odd_i ? pixel_blue_i : pixel_green_red_i;
	assign pix_l = {pix_a[1:0], pix_b[1:0], pix_a[1:0], pix_b[1:0]};

	always_comb begin
		if (lp_kind_i == tx_ctrl_pkg::LP_EMBEDDED) begin
			lane0_nxt = csi2_proto_pkg::EMB_END;
			lane1_nxt = csi2_proto_pkg::EMB_END;
			case (step_nxt)
				3'd0: lane0_nxt = csi2_proto_pkg::EMB_FORMAT;
				3'd2: lane0_nxt = csi2_proto_pkg::EMB_DUMMY;
				3'd4: lane1_nxt = csi2_proto_pkg::EMB_DUMMY;
				default: ;
			endcase
		end else begin
			case (step_nxt)
				3'd2: begin
					lane0_nxt = pix_l;
					lane1_nxt = pix_a[9:2];
				end
				3'd3: begin
					lane0_nxt = pix_b[9:2];
					lane1_nxt = pix_a[9:2];
				end
				3'd4: begin
					lane0_nxt = pix_b[9:2];
					lane1_nxt = pix_l;
				end
				default: begin  // Steps 0 and 1
					lane0_nxt = pix_a[9:2];
					lane1_nxt = pix_b[9:2];
				end
			endcase
		end
	end

	always_ff @(posedge ctrl_tx_byte_clk_i or negedge ctrl_tx_reset_i) begin
		if (!ctrl_tx_reset_i) begin
			step_q  <= 3'd0;
			beat_q  <= '0;
			lane0_q <= '0;
			lane1_q <= '0;
		end else begin
			step_q  <= step_nxt;
			beat_q  <= payload_run_i ? beat_q + 1'b1 : '0;
			lane0_q <= lane0_nxt;  // First beat preloaded while idle
			lane1_q <= lane1_nxt;
		end
	end

	assign last_beat = (lp_kind_i == tx_ctrl_pkg::LP_EMBEDDED) ? EMB_LAST : PIX_LAST;
	assign payload_last_o = payload_run_i && (beat_q == last_beat);

	// Lanes read zero outside a payload
	assign lane0_o = payload_run_i ? lane0_q : '0;
	assign lane1_o = payload_run_i ? lane1_q : '0;

endmodule

//--- design/csi2_tx_ctrl_top.sv
`timescale 1ns/100ps

module csi2_tx_ctrl_top (
	input  logic                        ctrl_tx_byte_clk_i,
	input  logic                        ctrl_tx_reset_i,
	input  logic                        ctrl_tx_pll_lock_i,
	input  logic                        ctrl_tx_tinit_done_i,
	input  logic                        ctrl_tx_start_stream_i,
	input  logic                        ctrl_tx_c2d_ready_i,
	input  logic                        ctrl_tx_d_hs_rdy_i,
	input  logic                        ctrl_tx_ld_pyld_i,
	input  csi2_proto_pkg::pixel_t      ctrl_tx_pixel_red_i,
	input  csi2_proto_pkg::pixel_t      ctrl_tx_pixel_green_red_i,
	input  csi2_proto_pkg::pixel_t      ctrl_tx_pixel_green_blue_i,
	input  csi2_proto_pkg::pixel_t      ctrl_tx_pixel_blue_i,
	output logic [15:0]                 ctrl_tx_byte_data_o,
	output csi2_proto_pkg::data_type_t  ctrl_tx_dt_o,
	output csi2_proto_pkg::word_count_t ctrl_tx_wc_o,
	output logic                        ctrl_tx_byte_data_en_o,
	output logic                        ctrl_tx_clk_hs_en_o,
	output logic                        ctrl_tx_d_hs_en_o,
	output logic                        ctrl_tx_lp_en_o,
	output logic                        ctrl_tx_sp_en_o,
	output tx_ctrl_pkg::line_count_t    ctrl_tx_line_num_o
);

	logic link_up;
	logic stream_on;
	logic link_drop;
	logic payload_run;
	logic payload_last;
	logic line_odd;
	tx_ctrl_pkg::lp_kind_t lp_kind;
	csi2_proto_pkg::lane_byte_t lane0;
	csi2_proto_pkg::lane_byte_t lane1;

	link_bringup u_link_bringup (
		.ctrl_tx_byte_clk_i(ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i   (ctrl_tx_reset_i),
		.pll_lock_i        (ctrl_tx_pll_lock_i),
		.tinit_done_i      (ctrl_tx_tinit_done_i),
		.start_stream_i    (ctrl_tx_start_stream_i),
		.link_drop_i       (link_drop),
		.link_up_o         (link_up),
		.stream_on_o       (stream_on)
	);

	packet_sequencer u_packet_sequencer (
		.ctrl_tx_byte_clk_i(ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i   (ctrl_tx_reset_i),
		.link_up_i         (link_up),
		.stream_on_i       (stream_on),
		.c2d_ready_i       (ctrl_tx_c2d_ready_i),
		.d_hs_rdy_i        (ctrl_tx_d_hs_rdy_i),
		.ld_pyld_i         (ctrl_tx_ld_pyld_i),
		.payload_last_i    (payload_last),
		.link_drop_o       (link_drop),
		.clk_hs_en_o       (ctrl_tx_clk_hs_en_o),
		.d_hs_en_o         (ctrl_tx_d_hs_en_o),
		.sp_en_o           (ctrl_tx_sp_en_o),
		.lp_en_o           (ctrl_tx_lp_en_o),
		.payload_run_o     (payload_run),
		.lp_kind_o         (lp_kind),
		.line_odd_o        (line_odd),
		.dt_o              (ctrl_tx_dt_o),
		.wc_o              (ctrl_tx_wc_o),
		.line_num_o        (ctrl_tx_line_num_o)
	);

	payload_gen u_payload_gen (
		.ctrl_tx_byte_clk_i(ctrl_tx_byte_clk_i),
		.ctrl_tx_reset_i   (ctrl_tx_reset_i),
		.payload_run_i     (payload_run),
		.lp_kind_i         (lp_kind),
		.line_odd_i        (line_odd),
		.pixel_red_i       (ctrl_tx_pixel_red_i),
		.pixel_green_red_i (ctrl_tx_pixel_green_red_i),
		.pixel_green_blue_i(ctrl_tx_pixel_green_blue_i),
		.pixel_blue_i      (ctrl_tx_pixel_blue_i),
		.lane0_o           (lane0),
		.lane1_o           (lane1),
		.payload_last_o    (payload_last)
	);

	assign ctrl_tx_byte_data_o    = {lane1, lane0};  // Lane 1 in the upper byte
	assign ctrl_tx_byte_data_en_o = payload_run;

endmodule

//--- verif/csi2_ip_model.sv
`timescale 1ns/100ps

module csi2_ip_model (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic d_hs_en_i,
	input  logic sp_en_i,
	input  logic lp_en_i,
	input  logic data_en_i,
	output logic c2d_ready_o,
	output logic d_hs_rdy_o,
	output logic ld_pyld_o
);

	logic [31:0] lcg_q;
	logic data_pending;  // Long packet whose payload has not started yet
	int hs_wait;
	int c2d_wait;
	int pyld_wait;

	// Next response delay, 1 to 8 cycles
	function automatic int next_delay();
		lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
		return int'(lcg_q[30:28]) + 1;
	endfunction

	initial begin
		lcg_q        = 32'hf3b7542f;
		data_pending = 1'b0;
		hs_wait      = 0;
		c2d_wait     = 0;
		pyld_wait    = 0;
		c2d_ready_o  = 1'b0;
		d_hs_rdy_o   = 1'b0;
		ld_pyld_o    = 1'b0;
		forever begin
			@(posedge clk_i);
			#1;
			if (!rst_n_i) begin
				c2d_ready_o = 1'b1;  // Ready once out of reset
				d_hs_rdy_o  = 1'b0;
				ld_pyld_o   = 1'b0;
			end else begin
				// Lane reports HS mode some time after the request pulse
				if (d_hs_en_i) begin
					d_hs_rdy_o = 1'b0;
					hs_wait    = next_delay();
				end else if (hs_wait > 0) begin
					hs_wait    = hs_wait - 1;
					d_hs_rdy_o = (hs_wait == 0);
				end
				if (sp_en_i || lp_en_i) begin
					c2d_ready_o  = 1'b0;
					data_pending = lp_en_i;
					c2d_wait     = next_delay();
				end else if (data_en_i) begin
					data_pending = 1'b0;  // Busy until the payload is through
				end else if (!data_pending && c2d_wait > 0) begin
					c2d_wait    = c2d_wait - 1;
					c2d_ready_o = (c2d_wait == 0);
				end
				if (lp_en_i) begin
					ld_pyld_o = 1'b1;
					pyld_wait = next_delay();
				end else if (pyld_wait > 0) begin
					pyld_wait = pyld_wait - 1;
					ld_pyld_o = (pyld_wait != 0);
				end
			end
		end
	end

endmodule

//--- verif/tb_csi2_tx_ctrl.sv
`timescale 1ns/100ps
`include "csi2_tx_settings.svh"

module tb_csi2_tx_ctrl;

	localparam int NUM_ROWS = 4;
	localparam int QUIET = 30;  // Idle cycles between bring-up steps and after a stop
	localparam int PKT_WORST = `CSI2_HS_PULSE + `CSI2_PKT_EN_DELAY + `CSI2_LINE_BYTES / 2 + 40;
	localparam int FRAME_WORST = (`CSI2_PIXEL_LINES + 4) * PKT_WORST + `CSI2_EXPOSURE + 20;
	localparam int CYCLE_LIMIT = NUM_ROWS * (FRAME_WORST + QUIET + 20) + 3 * QUIET + 50;

	typedef struct packed {
		logic [9:0]  red;
		logic [9:0]  green_red;
		logic [9:0]  green_blue;
		logic [9:0]  blue;
		logic [15:0] frame_count;
		logic        stop_after;  // Stream request drops after this frame
	} frame_row_t;

	logic byte_clk;
	logic reset_n;
	logic pll_lock;
	logic tinit_done;
	logic start_stream;
	logic c2d_ready;
	logic d_hs_rdy;
	logic ld_pyld;
	logic [9:0] pixel_red;
	logic [9:0] pixel_green_red;
	logic [9:0] pixel_green_blue;
	logic [9:0] pixel_blue;
	logic [15:0] byte_data;
	logic [5:0] dt;
	logic [15:0] wc;
	logic data_en;
	logic clk_hs_en;
	logic d_hs_en;
	logic lp_en;
	logic sp_en;
	logic [11:0] line_num;
	logic packets_allowed;
	logic pulse_prev;
	frame_row_t rows [NUM_ROWS];
	int error_count;
	int cycle_count;
	int hs_len;
	int row;

	csi2_tx_ctrl_top csi2_tx_ctrl_top_i (
		.ctrl_tx_byte_clk_i        (byte_clk),
		.ctrl_tx_reset_i           (reset_n),
		.ctrl_tx_pll_lock_i        (pll_lock),
		.ctrl_tx_tinit_done_i      (tinit_done),
		.ctrl_tx_start_stream_i    (start_stream),
		.ctrl_tx_c2d_ready_i       (c2d_ready),
		.ctrl_tx_d_hs_rdy_i        (d_hs_rdy),
		.ctrl_tx_ld_pyld_i         (ld_pyld),
		.ctrl_tx_pixel_red_i       (pixel_red),
		.ctrl_tx_pixel_green_red_i (pixel_green_red),
		.ctrl_tx_pixel_green_blue_i(pixel_green_blue),
		.ctrl_tx_pixel_blue_i      (pixel_blue),
		.ctrl_tx_byte_data_o       (byte_data),
		.ctrl_tx_dt_o              (dt),
		.ctrl_tx_wc_o              (wc),
		.ctrl_tx_byte_data_en_o    (data_en),
		.ctrl_tx_clk_hs_en_o       (clk_hs_en),
		.ctrl_tx_d_hs_en_o         (d_hs_en),
		.ctrl_tx_lp_en_o           (lp_en),
		.ctrl_tx_sp_en_o           (sp_en),
		.ctrl_tx_line_num_o        (line_num)
	);

	csi2_ip_model u_ip_model (
		.clk_i      (byte_clk),
		.rst_n_i    (reset_n),
		.d_hs_en_i  (d_hs_en),
		.sp_en_i    (sp_en),
		.lp_en_i    (lp_en),
		.data_en_i  (data_en),
		.c2d_ready_o(c2d_ready),
		.d_hs_rdy_o (d_hs_rdy),
		.ld_pyld_o  (ld_pyld)
	);

	always #10 byte_clk = ~byte_clk;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic fail_run(input string what);
		error_count = error_count + 1;
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic next_cycle();
		@(posedge byte_clk);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			check_value("byte_data", 32'(byte_data), 32'h0);
			next_cycle();
		end
	endtask

	// RAW10 gear as (lane0 lane1) pairs (A B) (A B) (L A) (B A) (B L)
	// Result packs lane1 over lane0
	function automatic logic [15:0] pixel_beat(input logic [9:0] a, input logic [9:0] b,
		input int beat);
		logic [7:0] low;
		low = {a[1:0], b[1:0], a[1:0], b[1:0]};
		case (beat % 5)
			0, 1: pixel_beat = {b[9:2], a[9:2]};
			2: pixel_beat = {a[9:2], low};
			3: pixel_beat = {a[9:2], b[9:2]};
			default: pixel_beat = {low, b[9:2]};
		endcase
	endfunction

	function automatic logic [15:0] embedded_beat(input int beat);
		case (beat % 5)
			0: embedded_beat = 16'h070A;  // Format code on lane 0
			2: embedded_beat = 16'h0755;
			4: embedded_beat = 16'h5507;
			default: embedded_beat = 16'h0707;
		endcase
	endfunction

	task automatic expect_header(input logic is_short, input logic [5:0] exp_dt,
		input logic [15:0] exp_wc);
		while (!(sp_en || lp_en)) begin
			check_value("byte_data", 32'(byte_data), 32'h0);
			next_cycle();
		end
		check_value("sp_en", 32'(sp_en), 32'(is_short));
		check_value("dt", 32'(dt), 32'(exp_dt));
		check_value("wc", 32'(wc), 32'(exp_wc));
	endtask

	task automatic check_payload(input logic is_pixel, input logic [9:0] a,
		input logic [9:0] b);
		int beats;
		int n;
		logic [15:0] exp_data;
		beats = is_pixel ? `CSI2_LINE_BYTES / 2 : `CSI2_EMBEDDED_BYTES / 2;
		next_cycle();
		while (!data_en) begin
			check_value("byte_data", 32'(byte_data), 32'h0);
			next_cycle();
		end
		for (n = 0; n < beats; n++) begin
			exp_data = is_pixel ? pixel_beat(a, b, n) : embedded_beat(n);
			check_value("byte_data_en", 32'(data_en), 32'h1);
			check_value("byte_data", 32'(byte_data), 32'(exp_data));
			next_cycle();
		end
		check_value("byte_data_en", 32'(data_en), 32'h0);  // No extra beat
	endtask

	task automatic run_frame(input frame_row_t fr);
		int line;
		expect_header(1'b1, 6'h00, fr.frame_count);  // Frame Start
		next_cycle();
		for (line = 0; line < 2; line++) begin
			expect_header(1'b0, 6'h12, 16'(`CSI2_EMBEDDED_BYTES));
			check_payload(1'b0, 10'h0, 10'h0);
		end
		for (line = 0; line < `CSI2_PIXEL_LINES; line++) begin
			expect_header(1'b0, 6'h2B, 16'(`CSI2_LINE_BYTES));
			check_value("line_num", 32'(line_num), 32'(`CSI2_PIXEL_LINES - line));
			if (line % 2 == 0) begin
				check_payload(1'b1, fr.red, fr.green_red);  // R/Gr row
			end else begin
				check_payload(1'b1, fr.green_blue, fr.blue);
			end
		end
		expect_header(1'b1, 6'h01, fr.frame_count);
	endtask

	// HS pulse length, enable pairing and quiet periods
	always @(negedge byte_clk) begin
		if (reset_n) begin
			check_value("d_hs_en", 32'(d_hs_en), 32'(clk_hs_en));
			if (!packets_allowed && (clk_hs_en || sp_en || lp_en || data_en)) begin
				fail_run("HS request or packet enable while the stream is not requested");
			end
			if ((sp_en || lp_en) && pulse_prev) begin
				fail_run("sp_en or lp_en held high for more than one cycle");
			end
			pulse_prev = sp_en || lp_en;
			if (clk_hs_en) begin
				hs_len = hs_len + 1;
			end else if (hs_len != 0) begin
				check_value("hs pulse length", hs_len, `CSI2_HS_PULSE);
				hs_len = 0;
			end
		end
	end

	always @(posedge byte_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			fail_run($sformatf("Timeout after %0d cycles before all frames were seen",
				cycle_count));
		end
	end

	initial begin
		byte_clk         = 1'b0;
		reset_n          = 1'b0;
		pll_lock         = 1'b0;
		tinit_done       = 1'b0;
		start_stream     = 1'b0;
		pixel_red        = '0;
		pixel_green_red  = '0;
		pixel_green_blue = '0;
		pixel_blue       = '0;
		packets_allowed  = 1'b0;
		pulse_prev       = 1'b0;
		error_count      = 0;
		cycle_count      = 0;
		hs_len           = 0;
		rows[0] = '{10'h3a5, 10'h1c6, 10'h2f1, 10'h09e, 16'd1, 1'b0};
		rows[1] = '{10'h0ff, 10'h300, 10'h155, 10'h2aa, 16'd2, 1'b0};
		rows[2] = '{10'h201, 10'h17c, 10'h3fe, 10'h043, 16'd3, 1'b1};
		rows[3] = '{10'h0d7, 10'h36b, 10'h12e, 10'h3c9, 16'd1, 1'b0};  // Restart count
		repeat (3) @(posedge byte_clk);
		#1;
		reset_n = 1'b1;
		// Bring-up one step at a time, each gap longer than the settle path
		idle_cycles(QUIET);
		pll_lock = 1'b1;
		idle_cycles(QUIET);
		tinit_done = 1'b1;
		idle_cycles(QUIET);
		start_stream    = 1'b1;
		packets_allowed = 1'b1;
		for (row = 0; row < NUM_ROWS; row++) begin
			pixel_red        = rows[row].red;
			pixel_green_red  = rows[row].green_red;
			pixel_green_blue = rows[row].green_blue;
			pixel_blue       = rows[row].blue;
			run_frame(rows[row]);
			if (rows[row].stop_after) begin
				start_stream = 1'b0;  // Seen at the frame boundary after FE
			end
			next_cycle();
			if (rows[row].stop_after) begin
				packets_allowed = 1'b0;
				idle_cycles(QUIET);
				start_stream    = 1'b1;
				packets_allowed = 1'b1;
			end
		end
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+design
design/csi2_proto_pkg.sv
design/tx_ctrl_pkg.sv
design/delay_timer.sv
design/link_bringup.sv
design/packet_sequencer.sv
design/payload_gen.sv
design/csi2_tx_ctrl_top.sv
verif/csi2_ip_model.sv
verif/tb_csi2_tx_ctrl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_csi2_tx_ctrl

status=0
./obj_dir/Vtb_csi2_tx_ctrl > sim.log 2>&1 || status=$?
cat sim.log
echo "Simulator exit status: $status"

if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
